// File: logic/shadow_consts.svh
/*
 * widths of the link frame and of the shadow registers
 * common reset value of the shadow copy
 * register addresses of the high-voltage die map
 */
`ifndef SHADOW_CONSTS_SVH
`define SHADOW_CONSTS_SVH

// ==========================================================
// widths
// ==========================================================
`define SHADOW_REG_DW   10
`define SHADOW_ADC_DW   12
`define OWT_CMD_W       8
// one frame carries both adc results
`define OWT_DATA_W      24
`define SHADOW_ADDR_W   7
`define SHADOW_RST_VAL  0

// ==========================================================
// register map, fixed by the hv die
// ==========================================================
`define SHADOW_ADDR_EFUSE_CONFIG  7'h06
`define SHADOW_ADDR_EFUSE_STATUS  7'h07
`define SHADOW_ADDR_STATUS1       7'h08
`define SHADOW_ADDR_STATUS2       7'h0A
`define SHADOW_ADDR_STATUS3       7'h0C
`define SHADOW_ADDR_STATUS4       7'h0D
`define SHADOW_ADDR_BIST1         7'h14
`define SHADOW_ADDR_BIST2         7'h15
`define SHADOW_ADDR_ADC           7'h1F

`endif

// File: logic/owt_pkg.sv
/*
 * one-wire link side types
 *   owt_op_e    opcode taken from the command top bit
 *   owt_cmd_t   command field
 *   owt_data_t  frame data field
 */
`include "shadow_consts.svh"

package owt_pkg;

    // ==========================================================
    // opcode
    // ==========================================================
    // top bit of the command, set for a write
    typedef enum logic {
        OWT_OP_READ  = 1'b0,
        OWT_OP_WRITE = 1'b1
    } owt_op_e;

    // ==========================================================
    // frame fields
    // ==========================================================
    // opcode bit on top, register address below it
    typedef logic [`OWT_CMD_W-1:0] owt_cmd_t;

    // low bits for plain registers, two adc results for the adc address
    typedef logic [`OWT_DATA_W-1:0] owt_data_t;

endpackage

// File: logic/shadow_map_pkg.sv
/*
 * shadow register map types
 *   shadow_addr_e  addresses of the mirrored hv registers
 *   reg_word_t     plain register value
 *   adc_word_t     one adc result
 */
`include "shadow_consts.svh"

package shadow_map_pkg;

    // ==========================================================
    // addresses
    // ==========================================================
    // gaps in the map are unmapped, a write there is dropped
    typedef enum logic [`SHADOW_ADDR_W-1:0] {
        ADDR_EFUSE_CONFIG = `SHADOW_ADDR_EFUSE_CONFIG,
        ADDR_EFUSE_STATUS = `SHADOW_ADDR_EFUSE_STATUS,
        ADDR_STATUS1      = `SHADOW_ADDR_STATUS1,
        ADDR_STATUS2      = `SHADOW_ADDR_STATUS2,
        ADDR_STATUS3      = `SHADOW_ADDR_STATUS3,
        ADDR_STATUS4      = `SHADOW_ADDR_STATUS4,
        ADDR_BIST1        = `SHADOW_ADDR_BIST1,
        ADDR_BIST2        = `SHADOW_ADDR_BIST2,
        // adc1 and adc2 share this one
        ADDR_ADC          = `SHADOW_ADDR_ADC
    } shadow_addr_e;

    // ==========================================================
    // register words
    // ==========================================================
    typedef logic [`SHADOW_REG_DW-1:0] reg_word_t;

    typedef logic [`SHADOW_ADC_DW-1:0] adc_word_t;

endpackage

// File: logic/owt_frame_decode.sv
/*
 * frame decoder for the one-wire receiver output
 *   write strobe for acknowledged, error-free write frames
 *   address and data split out of the frame
 *   registered echo of every acknowledged frame
 */
`timescale 1ns/1ns
`include "shadow_consts.svh"

module owt_frame_decode (
    input  logic                          i_clk,
    input  logic                          i_rst_n,

    input  logic                          i_owt_rx_ack,
    input  owt_pkg::owt_cmd_t             i_owt_rx_cmd,
    input  owt_pkg::owt_data_t            i_owt_rx_data,
    input  logic                          i_owt_rx_status,

    output logic                          o_wr_en,
    output shadow_map_pkg::shadow_addr_e  o_wr_addr,
    output owt_pkg::owt_data_t            o_wr_data,

    output logic                          o_hv_reg_vld,
    output shadow_map_pkg::reg_word_t     o_hv_ang_reg_data
);

    owt_pkg::owt_op_e rx_op;

    // ==========================================================
    // command split
    // ==========================================================
    assign rx_op = owt_pkg::owt_op_e'(i_owt_rx_cmd[`OWT_CMD_W-1]);

    // unmapped addresses pass through, the bank ignores them
    assign o_wr_addr = shadow_map_pkg::shadow_addr_e'(i_owt_rx_cmd[`SHADOW_ADDR_W-1:0]);
    assign o_wr_data = i_owt_rx_data;

    // status high marks a frame the receiver flagged as errored
    assign o_wr_en = i_owt_rx_ack & ~i_owt_rx_status & (rx_op == owt_pkg::OWT_OP_WRITE);

    // ==========================================================
    // echo
    // ==========================================================
    // every ack is echoed, reads and errored frames too
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hv_reg_vld <= 1'b0;
        end else begin
            o_hv_reg_vld <= i_owt_rx_ack;
        end
    end

    // sampled every cycle, qualified only by the valid
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hv_ang_reg_data <= shadow_map_pkg::reg_word_t'(`SHADOW_RST_VAL);
        end else begin
            o_hv_ang_reg_data <= i_owt_rx_data[`SHADOW_REG_DW-1:0];
        end
    end

    // a strobe comes only from an acked frame
    a_wr_en_acked: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_wr_en |-> i_owt_rx_ack
    );

endmodule

// File: logic/shadow_reg_bank.sv
/*
 * low-voltage copy of the hv die registers
 *   efuse config and status, status 1 to 4, bist 1 and 2
 *   adc1 and adc2 results loaded from one frame
 * address decode only, the strobe is qualified upstream
 */
`timescale 1ns/1ns
`include "shadow_consts.svh"

module shadow_reg_bank (
    input  logic                          i_clk,
    input  logic                          i_rst_n,

    input  logic                          i_wr_en,
    input  shadow_map_pkg::shadow_addr_e  i_wr_addr,
    input  owt_pkg::owt_data_t            i_wr_data,

    output shadow_map_pkg::reg_word_t     o_reg_efuse_config,
    output shadow_map_pkg::reg_word_t     o_reg_efuse_status,
    output shadow_map_pkg::reg_word_t     o_reg_status1,
    output shadow_map_pkg::reg_word_t     o_reg_status2,
    output shadow_map_pkg::reg_word_t     o_reg_status3,
    output shadow_map_pkg::reg_word_t     o_reg_status4,
    output shadow_map_pkg::reg_word_t     o_reg_bist1,
    output shadow_map_pkg::reg_word_t     o_reg_bist2,
    output shadow_map_pkg::adc_word_t     o_reg_adc1_data,
    output shadow_map_pkg::adc_word_t     o_reg_adc2_data
);

    shadow_map_pkg::reg_word_t wr_word;
    shadow_map_pkg::adc_word_t wr_adc_lo;
    shadow_map_pkg::adc_word_t wr_adc_hi;

    // ==========================================================
    // write data slices
    // ==========================================================
    assign wr_word   = i_wr_data[`SHADOW_REG_DW-1:0];
    assign wr_adc_lo = i_wr_data[`SHADOW_ADC_DW-1:0];
    assign wr_adc_hi = i_wr_data[`OWT_DATA_W-1 -: `SHADOW_ADC_DW];

    // ==========================================================
    // registers
    // ==========================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_reg_efuse_config <= shadow_map_pkg::reg_word_t'(`SHADOW_RST_VAL);
            o_reg_efuse_status <= shadow_map_pkg::reg_word_t'(`SHADOW_RST_VAL);
            o_reg_status1      <= shadow_map_pkg::reg_word_t'(`SHADOW_RST_VAL);
            o_reg_status2      <= shadow_map_pkg::reg_word_t'(`SHADOW_RST_VAL);
            o_reg_status3      <= shadow_map_pkg::reg_word_t'(`SHADOW_RST_VAL);
            o_reg_status4      <= shadow_map_pkg::reg_word_t'(`SHADOW_RST_VAL);
            o_reg_bist1        <= shadow_map_pkg::reg_word_t'(`SHADOW_RST_VAL);
            o_reg_bist2        <= shadow_map_pkg::reg_word_t'(`SHADOW_RST_VAL);
            o_reg_adc1_data    <= shadow_map_pkg::adc_word_t'(`SHADOW_RST_VAL);
            o_reg_adc2_data    <= shadow_map_pkg::adc_word_t'(`SHADOW_RST_VAL);
        end else if (i_wr_en) begin
            case (i_wr_addr)
                shadow_map_pkg::ADDR_EFUSE_CONFIG: begin
                    o_reg_efuse_config <= wr_word;
                end
                shadow_map_pkg::ADDR_EFUSE_STATUS: begin
                    o_reg_efuse_status <= wr_word;
                end
                shadow_map_pkg::ADDR_STATUS1: begin
                    o_reg_status1 <= wr_word;
                end
                shadow_map_pkg::ADDR_STATUS2: begin
                    o_reg_status2 <= wr_word;
                end
                shadow_map_pkg::ADDR_STATUS3: begin
                    o_reg_status3 <= wr_word;
                end
                shadow_map_pkg::ADDR_STATUS4: begin
                    o_reg_status4 <= wr_word;
                end
                shadow_map_pkg::ADDR_BIST1: begin
                    o_reg_bist1 <= wr_word;
                end
                shadow_map_pkg::ADDR_BIST2: begin
                    o_reg_bist2 <= wr_word;
                end
                // both adc results in one frame, adc1 in the low half
                shadow_map_pkg::ADDR_ADC: begin
                    o_reg_adc1_data <= wr_adc_lo;
                    o_reg_adc2_data <= wr_adc_hi;
                end
                default: begin
                    // unmapped, shadow copy untouched
                end
            endcase
        end
    end

    // ==========================================================
    // checks
    // ==========================================================
    // without a strobe the whole bank holds over the next edge
    a_hold_without_wr: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_wr_en |=> $stable({o_reg_efuse_config, o_reg_efuse_status,
                              o_reg_status1, o_reg_status2,
                              o_reg_status3, o_reg_status4,
                              o_reg_bist1, o_reg_bist2,
                              o_reg_adc1_data, o_reg_adc2_data})
    );

endmodule

// File: logic/lv_hv_shadow_top.sv
/*
 * lv side shadow of the hv die registers
 *   frame decoder with echo path
 *   address-decoded shadow register bank
 */
`timescale 1ns/1ns

module lv_hv_shadow_top (
    input  logic                       i_clk,
    input  logic                       i_rst_n,

    // from the one-wire receiver
    input  logic                       i_owt_rx_ack,
    input  owt_pkg::owt_cmd_t          i_owt_rx_cmd,
    input  owt_pkg::owt_data_t         i_owt_rx_data,
    input  logic                       i_owt_rx_status,

    output shadow_map_pkg::reg_word_t  o_reg_efuse_config,
    output shadow_map_pkg::reg_word_t  o_reg_efuse_status,
    output shadow_map_pkg::reg_word_t  o_reg_status1,
    output shadow_map_pkg::reg_word_t  o_reg_status2,
    output shadow_map_pkg::reg_word_t  o_reg_status3,
    output shadow_map_pkg::reg_word_t  o_reg_status4,
    output shadow_map_pkg::reg_word_t  o_reg_bist1,
    output shadow_map_pkg::reg_word_t  o_reg_bist2,
    output shadow_map_pkg::adc_word_t  o_reg_adc1_data,
    output shadow_map_pkg::adc_word_t  o_reg_adc2_data,

    // echo of each acked frame
    output logic                       o_hv_reg_vld,
    output shadow_map_pkg::reg_word_t  o_hv_ang_reg_data
);

    logic                          wr_en;
    shadow_map_pkg::shadow_addr_e  wr_addr;
    owt_pkg::owt_data_t            wr_data;

    // ==========================================================
    // frame decode
    // ==========================================================
    owt_frame_decode owt_frame_decode_i (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_owt_rx_ack      (i_owt_rx_ack),
        .i_owt_rx_cmd      (i_owt_rx_cmd),
        .i_owt_rx_data     (i_owt_rx_data),
        .i_owt_rx_status   (i_owt_rx_status),
        .o_wr_en           (wr_en),
        .o_wr_addr         (wr_addr),
        .o_wr_data         (wr_data),
        .o_hv_reg_vld      (o_hv_reg_vld),
        .o_hv_ang_reg_data (o_hv_ang_reg_data)
    );

    // ==========================================================
    // register bank
    // ==========================================================
    shadow_reg_bank shadow_reg_bank_i (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_wr_en            (wr_en),
        .i_wr_addr          (wr_addr),
        .i_wr_data          (wr_data),
        .o_reg_efuse_config (o_reg_efuse_config),
        .o_reg_efuse_status (o_reg_efuse_status),
        .o_reg_status1      (o_reg_status1),
        .o_reg_status2      (o_reg_status2),
        .o_reg_status3      (o_reg_status3),
        .o_reg_status4      (o_reg_status4),
        .o_reg_bist1        (o_reg_bist1),
        .o_reg_bist2        (o_reg_bist2),
        .o_reg_adc1_data    (o_reg_adc1_data),
        .o_reg_adc2_data    (o_reg_adc2_data)
    );

endmodule

// File: verification/lv_hv_shadow_tb.sv
/*
 * testbench for the lv side shadow register bank
 *   clock, reset and lcg data source
 *   register model and compare tasks
 *   directed tests for reset, writes, adc, ignored frames and bursts
 *   watchdog
 */
`timescale 1ns/1ns
`include "shadow_consts.svh"

module lv_hv_shadow_tb;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 4;
    localparam int BURST_LEN       = 24;
    localparam int WATCHDOG_CYCLES = 2000;

    logic                        clk;
    logic                        rst_n;
    logic                        ack;
    owt_pkg::owt_cmd_t           cmd;
    owt_pkg::owt_data_t          data;
    logic                        status;

    shadow_map_pkg::reg_word_t   reg_efuse_config;
    shadow_map_pkg::reg_word_t   reg_efuse_status;
    shadow_map_pkg::reg_word_t   reg_status1;
    shadow_map_pkg::reg_word_t   reg_status2;
    shadow_map_pkg::reg_word_t   reg_status3;
    shadow_map_pkg::reg_word_t   reg_status4;
    shadow_map_pkg::reg_word_t   reg_bist1;
    shadow_map_pkg::reg_word_t   reg_bist2;
    shadow_map_pkg::adc_word_t   reg_adc1;
    shadow_map_pkg::adc_word_t   reg_adc2;
    logic                        hv_reg_vld;
    shadow_map_pkg::reg_word_t   hv_ang_reg_data;

    // slots 0 to 7 are the plain registers, slot 8 is the adc pair
    shadow_map_pkg::reg_word_t   model_regs [0:7];
    shadow_map_pkg::adc_word_t   model_adc1;
    shadow_map_pkg::adc_word_t   model_adc2;
    logic [31:0]                 lcg_state;

    lv_hv_shadow_top lv_hv_shadow_top_i (
        .i_clk              (clk),
        .i_rst_n            (rst_n),
        .i_owt_rx_ack       (ack),
        .i_owt_rx_cmd       (cmd),
        .i_owt_rx_data      (data),
        .i_owt_rx_status    (status),
        .o_reg_efuse_config (reg_efuse_config),
        .o_reg_efuse_status (reg_efuse_status),
        .o_reg_status1      (reg_status1),
        .o_reg_status2      (reg_status2),
        .o_reg_status3      (reg_status3),
        .o_reg_status4      (reg_status4),
        .o_reg_bist1        (reg_bist1),
        .o_reg_bist2        (reg_bist2),
        .o_reg_adc1_data    (reg_adc1),
        .o_reg_adc2_data    (reg_adc2),
        .o_hv_reg_vld       (hv_reg_vld),
        .o_hv_ang_reg_data  (hv_ang_reg_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==========================================================
    // helpers
    // ==========================================================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [3:0] addr_slot(logic [6:0] addr);
        case (addr)
            `SHADOW_ADDR_EFUSE_CONFIG: return 4'd0;
            `SHADOW_ADDR_EFUSE_STATUS: return 4'd1;
            `SHADOW_ADDR_STATUS1:      return 4'd2;
            `SHADOW_ADDR_STATUS2:      return 4'd3;
            `SHADOW_ADDR_STATUS3:      return 4'd4;
            `SHADOW_ADDR_STATUS4:      return 4'd5;
            `SHADOW_ADDR_BIST1:        return 4'd6;
            `SHADOW_ADDR_BIST2:        return 4'd7;
            `SHADOW_ADDR_ADC:          return 4'd8;
            default:                   return 4'hF;
        endcase
    endfunction

    function automatic logic [6:0] slot_addr(logic [3:0] slot);
        case (slot)
            4'd0:    return `SHADOW_ADDR_EFUSE_CONFIG;
            4'd1:    return `SHADOW_ADDR_EFUSE_STATUS;
            4'd2:    return `SHADOW_ADDR_STATUS1;
            4'd3:    return `SHADOW_ADDR_STATUS2;
            4'd4:    return `SHADOW_ADDR_STATUS3;
            4'd5:    return `SHADOW_ADDR_STATUS4;
            4'd6:    return `SHADOW_ADDR_BIST1;
            4'd7:    return `SHADOW_ADDR_BIST2;
            default: return `SHADOW_ADDR_ADC;
        endcase
    endfunction

    function automatic string reg_name(logic [2:0] slot);
        case (slot)
            3'd0:    return "efuse_config";
            3'd1:    return "efuse_status";
            3'd2:    return "status1";
            3'd3:    return "status2";
            3'd4:    return "status3";
            3'd5:    return "status4";
            3'd6:    return "bist1";
            default: return "bist2";
        endcase
    endfunction

    function automatic shadow_map_pkg::reg_word_t dut_reg(logic [2:0] slot);
        case (slot)
            3'd0:    return reg_efuse_config;
            3'd1:    return reg_efuse_status;
            3'd2:    return reg_status1;
            3'd3:    return reg_status2;
            3'd4:    return reg_status3;
            3'd5:    return reg_status4;
            3'd6:    return reg_bist1;
            default: return reg_bist2;
        endcase
    endfunction

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic drive_frame(owt_pkg::owt_op_e op, logic [6:0] addr,
                               owt_pkg::owt_data_t d, logic err);
        ack    = 1'b1;
        cmd    = {op, addr};
        data   = d;
        status = err;
    endtask

    task automatic drive_idle();
        ack    = 1'b0;
        status = 1'b0;
    endtask

    // only acked, error-free writes to a mapped address touch the model
    task automatic model_apply(owt_pkg::owt_op_e op, logic [6:0] addr,
                               owt_pkg::owt_data_t d, logic err);
        logic [3:0] slot;
        slot = addr_slot(addr);
        if (op == owt_pkg::OWT_OP_WRITE && !err) begin
            if (slot < 4'd8) begin
                model_regs[slot[2:0]] = d[`SHADOW_REG_DW-1:0];
            end else if (slot == 4'd8) begin
                model_adc1 = d[`SHADOW_ADC_DW-1:0];
                model_adc2 = d[`OWT_DATA_W-1:`SHADOW_ADC_DW];
            end
        end
    endtask

    // ==========================================================
    // compare tasks
    // ==========================================================
    task automatic check_reg(string tname, shadow_map_pkg::reg_word_t exp,
                             shadow_map_pkg::reg_word_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %03h, actual %03h", tname, exp, act);
            abort_run();
        end
    endtask

    task automatic check_adc(string tname, shadow_map_pkg::adc_word_t exp,
                             shadow_map_pkg::adc_word_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %03h, actual %03h", tname, exp, act);
            abort_run();
        end
    endtask

    // echo data follows the bus every cycle, valid or not
    task automatic check_echo(string tname, logic exp_vld,
                              shadow_map_pkg::reg_word_t exp_data);
        if (hv_reg_vld !== exp_vld) begin
            $display("FAIL %s echo valid: expected %0b, actual %0b",
                     tname, exp_vld, hv_reg_vld);
            abort_run();
        end
        if (hv_ang_reg_data !== exp_data) begin
            $display("FAIL %s echo data: expected %03h, actual %03h",
                     tname, exp_data, hv_ang_reg_data);
            abort_run();
        end
    endtask

    task automatic check_all_regs(string tname);
        logic [3:0] slot;
        for (slot = 4'd0; slot < 4'd8; slot = slot + 4'd1) begin
            check_reg({tname, " ", reg_name(slot[2:0])}, model_regs[slot[2:0]],
                      dut_reg(slot[2:0]));
        end
        check_adc({tname, " adc1"}, model_adc1, reg_adc1);
        check_adc({tname, " adc2"}, model_adc2, reg_adc2);
    endtask

    // one frame, then echo and bank checked one cycle after the ack
    task automatic send_and_check(string tname, owt_pkg::owt_op_e op,
                                  logic [6:0] addr, owt_pkg::owt_data_t d, logic err);
        @(negedge clk);
        drive_frame(op, addr, d, err);
        model_apply(op, addr, d, err);
        @(negedge clk);
        drive_idle();
        check_echo(tname, 1'b1, d[`SHADOW_REG_DW-1:0]);
        check_all_regs(tname);
        @(negedge clk);
        check_echo(tname, 1'b0, d[`SHADOW_REG_DW-1:0]);
    endtask

    // ==========================================================
    // directed tests
    // ==========================================================
    task automatic test_reset();
        check_echo("reset", 1'b0, '0);
        check_all_regs("reset");
    endtask

    task automatic test_mapped_writes();
        logic [3:0]  slot;
        logic [31:0] r;
        for (slot = 4'd0; slot < 4'd8; slot = slot + 4'd1) begin
            r = lcg_next();
            send_and_check("mapped_write", owt_pkg::OWT_OP_WRITE, slot_addr(slot),
                           r[`OWT_DATA_W-1:0], 1'b0);
        end
    endtask

    task automatic test_adc_write();
        logic [31:0] r;
        r = lcg_next();
        send_and_check("adc_write", owt_pkg::OWT_OP_WRITE, `SHADOW_ADDR_ADC,
                       r[`OWT_DATA_W-1:0], 1'b0);
        send_and_check("adc_write", owt_pkg::OWT_OP_WRITE, `SHADOW_ADDR_ADC,
                       24'hABC123, 1'b0);
    endtask

    task automatic test_ignored_frames();
        logic [31:0] r;
        r = lcg_next();
        send_and_check("errored_frame", owt_pkg::OWT_OP_WRITE, `SHADOW_ADDR_STATUS1,
                       r[`OWT_DATA_W-1:0], 1'b1);
        r = lcg_next();
        send_and_check("errored_adc", owt_pkg::OWT_OP_WRITE, `SHADOW_ADDR_ADC,
                       r[`OWT_DATA_W-1:0], 1'b1);
        r = lcg_next();
        send_and_check("read_frame", owt_pkg::OWT_OP_READ, `SHADOW_ADDR_BIST1,
                       r[`OWT_DATA_W-1:0], 1'b0);
        r = lcg_next();
        send_and_check("unmapped_00", owt_pkg::OWT_OP_WRITE, 7'h00, r[`OWT_DATA_W-1:0], 1'b0);
        r = lcg_next();
        send_and_check("unmapped_09", owt_pkg::OWT_OP_WRITE, 7'h09, r[`OWT_DATA_W-1:0], 1'b0);
        r = lcg_next();
        send_and_check("unmapped_7f", owt_pkg::OWT_OP_WRITE, 7'h7F, r[`OWT_DATA_W-1:0], 1'b0);
    endtask

    // 24 frames over 9 addresses, so some address is hit twice
    task automatic test_burst();
        logic [31:0]        r;
        logic [31:0]        pick;
        owt_pkg::owt_data_t d;
        owt_pkg::owt_data_t prev_d;
        int                 n;
        prev_d = '0;
        for (n = 0; n < BURST_LEN; n++) begin
            @(negedge clk);
            if (n > 0) begin
                check_echo("burst", 1'b1, prev_d[`SHADOW_REG_DW-1:0]);
            end
            pick = lcg_next() % 32'd9;
            r    = lcg_next();
            d    = r[`OWT_DATA_W-1:0];
            drive_frame(owt_pkg::OWT_OP_WRITE, slot_addr(pick[3:0]), d, 1'b0);
            model_apply(owt_pkg::OWT_OP_WRITE, slot_addr(pick[3:0]), d, 1'b0);
            prev_d = d;
        end
        @(negedge clk);
        drive_idle();
        check_echo("burst", 1'b1, prev_d[`SHADOW_REG_DW-1:0]);
        check_all_regs("burst");
        @(negedge clk);
        check_echo("burst", 1'b0, prev_d[`SHADOW_REG_DW-1:0]);
    endtask

    // ==========================================================
    // main sequence and watchdog
    // ==========================================================
    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        ack        = 1'b0;
        cmd        = '0;
        data       = '0;
        status     = 1'b0;
        lcg_state  = 32'h56feec0a;
        model_adc1 = '0;
        model_adc2 = '0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_mapped_writes();
        test_adc_write();
        test_ignored_frames();
        test_burst();
        $display("sim passed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

// File: list.f
+incdir+logic
logic/owt_pkg.sv
logic/shadow_map_pkg.sv
logic/owt_frame_decode.sv
logic/shadow_reg_bank.sv
logic/lv_hv_shadow_top.sv
verification/lv_hv_shadow_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       := lv_hv_shadow_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

# sources come from the file list, plus the shared header
SOURCES   := $(shell grep -v '^+' $(FILELIST)) logic/shadow_consts.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the binary exits non-zero on $fatal, so make fails with the run
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
